/* logic/rv_exec_pkg.sv */
package rv_exec_pkg;

  // ##################################################
  // widths
  // ##################################################
  localparam int xlen       = 64;
  localparam int reg_idx_w  = 5;
  localparam int dmem_depth = 32;
  localparam int dmem_idx_w = $clog2(dmem_depth);

  // store length codes, one bit per access size
  localparam logic [3:0] sl_byte  = 4'b0001;
  localparam logic [3:0] sl_half  = 4'b0010;
  localparam logic [3:0] sl_word  = 4'b0100;
  localparam logic [3:0] sl_dword = 4'b1000;

  // ##################################################
  // opcodes
  // ##################################################
  typedef enum logic [4:0] {
    alu_add  = 5'd0,
    alu_sub  = 5'd1,
    alu_sll  = 5'd2,
    alu_slt  = 5'd3,
    alu_sltu = 5'd4,
    alu_xor  = 5'd5,
    alu_srl  = 5'd6,
    alu_sra  = 5'd7,
    alu_or   = 5'd8,
    alu_and  = 5'd9,
    alu_lui  = 5'd10,
    alu_link = 5'd11
  } alu_op_e;

  // same encoding as the funct3 field
  typedef enum logic [2:0] {
    br_beq  = 3'd0,
    br_bne  = 3'd1,
    br_blt  = 3'd4,
    br_bge  = 3'd5,
    br_bltu = 3'd6,
    br_bgeu = 3'd7
  } branch_op_e;

  typedef enum logic [2:0] {
    ld_lb  = 3'd0,
    ld_lh  = 3'd1,
    ld_lw  = 3'd2,
    ld_ld  = 3'd3,
    ld_lbu = 3'd4,
    ld_lhu = 3'd5,
    ld_lwu = 3'd6
  } load_op_e;

  typedef enum logic [2:0] {
    wb_alu  = 3'd0,
    wb_load = 3'd1,
    wb_none = 3'd2
  } wb_sel_e;

  // ##################################################
  // stage structs
  // ##################################################
  typedef struct packed {
    logic [reg_idx_w-1:0] index_rd;
    logic [reg_idx_w-1:0] index_rs1;
    logic [reg_idx_w-1:0] index_rs2;
    logic                 jump_en;
    logic                 branch_en;
    logic                 alu_pc_en;
    logic                 alu_imm_en;
    logic                 alu_en;
    logic                 alu_halfop;
    alu_op_e              alu_opcode;
    branch_op_e           branch_opcode;
    logic [xlen-1:0]      pc;
    logic [xlen-1:0]      imm;
    logic [xlen-1:0]      gpr_data1;
    logic [xlen-1:0]      gpr_data2;
    logic                 load_en;
    logic                 store_en;
    load_op_e             load_opcode;
    logic [3:0]           store_len;
    logic                 wb_en;
    wb_sel_e              wb_choose;
  } dec_instr_t;

  typedef struct packed {
    logic [reg_idx_w-1:0] index_rd;
    logic [reg_idx_w-1:0] index_rs1;
    logic [reg_idx_w-1:0] index_rs2;
    logic                 jump_en;
    logic                 branch_en;
    logic [xlen-1:0]      branch_pc;
    logic                 branch_result;
    logic [xlen-1:0]      alu_result;
    logic [xlen-1:0]      gpr_data2;
    logic [xlen-1:0]      imm;
    logic                 load_en;
    load_op_e             load_opcode;
    logic                 store_en;
    logic [3:0]           store_len;
    logic                 wb_en;
    wb_sel_e              wb_choose;
  } ex_out_t;

  typedef struct packed {
    logic                 wb_valid;
    logic [reg_idx_w-1:0] index_rd;
    logic [xlen-1:0]      wb_data;
  } wb_out_t;

endpackage

/* logic/alu.sv */
`timescale 1ns/1ps

module alu import rv_exec_pkg::*; (
  input  dec_instr_t      instr,
  input  logic            fw_en1,
  input  logic            fw_en2,
  input  logic [xlen-1:0] fw_data,
  output logic [xlen-1:0] alu_result,
  output logic            branch_result
);

  logic [xlen-1:0] rs1_val;
  logic [xlen-1:0] rs2_val;
  logic [xlen-1:0] op1;
  logic [xlen-1:0] op2;
  logic [xlen-1:0] res64;
  logic [31:0]     a32;
  logic [31:0]     b32;
  logic [31:0]     res32;
  logic            taken;

  // ##################################################
  // operand selection
  // ##################################################
  assign rs1_val = fw_en1 ? fw_data : instr.gpr_data1;
  assign rs2_val = fw_en2 ? fw_data : instr.gpr_data2;

  assign op1 = instr.alu_pc_en  ? instr.pc  : rs1_val;
  assign op2 = instr.alu_imm_en ? instr.imm : rs2_val;

  assign a32 = op1[31:0];
  assign b32 = op2[31:0];

  // ##################################################
  // full width operations
  // ##################################################
  always_comb begin
    case (instr.alu_opcode)
      alu_add:  res64 = op1 + op2;
      alu_sub:  res64 = op1 - op2;
      alu_sll:  res64 = op1 << op2[5:0];
      alu_slt:  res64 = {{(xlen-1){1'b0}}, $signed(op1) < $signed(op2)};
      alu_sltu: res64 = {{(xlen-1){1'b0}}, op1 < op2};
      alu_xor:  res64 = op1 ^ op2;
      alu_srl:  res64 = op1 >> op2[5:0];
      alu_sra:  res64 = $signed(op1) >>> op2[5:0];
      alu_or:   res64 = op1 | op2;
      alu_and:  res64 = op1 & op2;
      alu_lui:  res64 = op2;
      alu_link: res64 = instr.pc + 64'd4;
      default:  res64 = '0;
    endcase
  end

  // ##################################################
  // word operations, sign extended below
  // ##################################################
  always_comb begin
    case (instr.alu_opcode)
      alu_add:  res32 = a32 + b32;
      alu_sub:  res32 = a32 - b32;
      alu_sll:  res32 = a32 << b32[4:0];
      alu_slt:  res32 = {31'b0, $signed(a32) < $signed(b32)};
      alu_sltu: res32 = {31'b0, a32 < b32};
      alu_xor:  res32 = a32 ^ b32;
      alu_srl:  res32 = a32 >> b32[4:0];
      alu_sra:  res32 = $signed(a32) >>> b32[4:0];
      alu_or:   res32 = a32 | b32;
      alu_and:  res32 = a32 & b32;
      alu_lui:  res32 = b32;
      alu_link: res32 = instr.pc[31:0] + 32'd4;
      default:  res32 = '0;
    endcase
  end

  always_comb begin
    if (!instr.alu_en) begin
      alu_result = '0;
    end else if (instr.alu_halfop) begin
      alu_result = {{32{res32[31]}}, res32};
    end else begin
      alu_result = res64;
    end
  end

  // ##################################################
  // branch compare
  // ##################################################
  // always on register operands, never on pc or imm
  always_comb begin
    case (instr.branch_opcode)
      br_beq:  taken = (rs1_val == rs2_val);
      br_bne:  taken = (rs1_val != rs2_val);
      br_blt:  taken = ($signed(rs1_val) < $signed(rs2_val));
      br_bge:  taken = ($signed(rs1_val) >= $signed(rs2_val));
      br_bltu: taken = (rs1_val < rs2_val);
      br_bgeu: taken = (rs1_val >= rs2_val);
      default: taken = 1'b0;
    endcase
  end

  assign branch_result = instr.branch_en & taken;

  // decode must never hand over an opcode outside the table
  always_comb begin
    if (instr.alu_en) begin
      assert (instr.alu_opcode inside {alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                                       alu_xor, alu_srl, alu_sra, alu_or, alu_and,
                                       alu_lui, alu_link})
      else $error("alu: unknown opcode %0d with alu_en set", instr.alu_opcode);
    end
  end

endmodule

/* logic/fwd_unit.sv */
`timescale 1ns/1ps

module fwd_unit import rv_exec_pkg::*; (
  input  dec_instr_t      instr,
  input  ex_out_t         ex,
  output logic            fw_en1,
  output logic            fw_en2,
  output logic [xlen-1:0] fw_data
);

  logic ex_writes_alu;

  // only alu results exist at this point, load data comes a cycle later
  assign ex_writes_alu = ex.wb_en
                         && (ex.wb_choose == wb_alu)
                         && (ex.index_rd != '0);

  // ##################################################
  // rs1 / rs2 match against the instruction in ex
  // ##################################################
  assign fw_en1 = ex_writes_alu && (instr.index_rs1 == ex.index_rd);
  assign fw_en2 = ex_writes_alu && (instr.index_rs2 == ex.index_rd);

  // one source value serves both operands
  assign fw_data = ex.alu_result;

endmodule

/* logic/exu.sv */
`timescale 1ns/1ps

module exu import rv_exec_pkg::*; (
  input  logic            clk,
  input  logic            rstn,
  input  logic            flush_nop,
  input  dec_instr_t      instr,
  input  logic            fw_en1,
  input  logic            fw_en2,
  input  logic [xlen-1:0] fw_data,
  output ex_out_t         ex
);

  logic [xlen-1:0] alu_result;
  logic            branch_result;
  logic [xlen-1:0] branch_pc;
  ex_out_t         ex_next;

  alu alu_inst (
    .instr         (instr),
    .fw_en1        (fw_en1),
    .fw_en2        (fw_en2),
    .fw_data       (fw_data),
    .alu_result    (alu_result),
    .branch_result (branch_result)
  );

  // target for both branches and jumps
  assign branch_pc = instr.pc + instr.imm;

  // ##################################################
  // next register value
  // ##################################################
  always_comb begin
    ex_next.index_rd      = instr.index_rd;
    ex_next.index_rs1     = instr.index_rs1;
    ex_next.index_rs2     = instr.index_rs2;
    ex_next.jump_en       = instr.jump_en;
    ex_next.branch_en     = instr.branch_en;
    ex_next.branch_pc     = branch_pc;
    ex_next.branch_result = branch_result;
    ex_next.alu_result    = alu_result;
    ex_next.gpr_data2     = instr.gpr_data2;
    ex_next.imm           = instr.imm;
    ex_next.load_en       = instr.load_en;
    ex_next.load_opcode   = instr.load_opcode;
    ex_next.store_en      = instr.store_en;
    ex_next.store_len     = instr.store_len;
    ex_next.wb_en         = instr.wb_en;
    ex_next.wb_choose     = instr.wb_choose;

    // wrong-path instruction keeps its data and loses every side effect
    if (flush_nop) begin
      ex_next.jump_en       = 1'b0;
      ex_next.branch_en     = 1'b0;
      ex_next.branch_result = 1'b0;
      ex_next.load_en       = 1'b0;
      ex_next.store_en      = 1'b0;
      ex_next.wb_en         = 1'b0;
    end
  end

  // ##################################################
  // execute register
  // ##################################################
  always_ff @(posedge clk) begin
    if (!rstn) begin
      ex.index_rd      <= '0;
      ex.jump_en       <= 1'b0;
      ex.branch_en     <= 1'b0;
      ex.branch_result <= 1'b0;
      ex.load_en       <= 1'b0;
      ex.store_en      <= 1'b0;
      ex.wb_en         <= 1'b0;
      ex.wb_choose     <= wb_none;
    end else begin
      ex <= ex_next;
    end
  end

  // decode hands over at most one control transfer per instruction
  a_one_transfer: assert property (
    @(posedge clk) disable iff (!rstn)
    !(instr.jump_en && instr.branch_en)
  ) else $error("exu: jump and branch both set");

endmodule

/* logic/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage import rv_exec_pkg::*; (
  input  logic    clk,
  input  logic    rstn,
  input  ex_out_t ex,
  output wb_out_t wb
);

  logic [xlen-1:0]       dmem [dmem_depth];
  logic [dmem_idx_w-1:0] word_idx;
  logic [2:0]            byte_off;
  logic [7:0]            st_be;
  logic [7:0]            wr_be;
  logic [xlen-1:0]       wr_data;
  logic [xlen-1:0]       rd_raw;
  logic [xlen-1:0]       load_val;
  logic [2:0]            size_mask;

  // doubleword index from bits 7:3, byte lane from bits 2:0
  assign word_idx = ex.alu_result[3 +: dmem_idx_w];
  assign byte_off = ex.alu_result[2:0];

  // ##################################################
  // store path
  // ##################################################
  always_comb begin
    case (ex.store_len)
      sl_byte:  st_be = 8'h01;
      sl_half:  st_be = 8'h03;
      sl_word:  st_be = 8'h0f;
      sl_dword: st_be = 8'hff;
      default:  st_be = 8'h00;
    endcase
  end

  assign wr_be   = st_be << byte_off;
  assign wr_data = ex.gpr_data2 << {byte_off, 3'b000};

  // zero fill on reset
  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < dmem_depth; i++) begin
        dmem[i] <= '0;
      end
    end else if (ex.store_en) begin
      for (int b = 0; b < 8; b++) begin
        if (wr_be[b]) begin
          dmem[word_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
        end
      end
    end
  end

  // ##################################################
  // load path
  // ##################################################
  assign rd_raw = dmem[word_idx] >> {byte_off, 3'b000};

  always_comb begin
    case (ex.load_opcode)
      ld_lb:   load_val = {{56{rd_raw[7]}}, rd_raw[7:0]};
      ld_lh:   load_val = {{48{rd_raw[15]}}, rd_raw[15:0]};
      ld_lw:   load_val = {{32{rd_raw[31]}}, rd_raw[31:0]};
      ld_ld:   load_val = rd_raw;
      ld_lbu:  load_val = {56'b0, rd_raw[7:0]};
      ld_lhu:  load_val = {48'b0, rd_raw[15:0]};
      ld_lwu:  load_val = {32'b0, rd_raw[31:0]};
      default: load_val = '0;
    endcase
  end

  // ##################################################
  // write-back register
  // ##################################################
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wb.wb_valid <= 1'b0;
    end else begin
      wb.wb_valid <= ex.wb_en && (ex.index_rd != '0);
    end
  end

  always_ff @(posedge clk) begin
    wb.index_rd <= ex.index_rd;
    case (ex.wb_choose)
      wb_alu:  wb.wb_data <= ex.alu_result;
      wb_load: wb.wb_data <= load_val;
      default: wb.wb_data <= '0;
    endcase
  end

  // byte offset bits covered by the access size
  always_comb begin
    size_mask = 3'd0;
    if (ex.load_en) begin
      case (ex.load_opcode)
        ld_lh, ld_lhu: size_mask = 3'd1;
        ld_lw, ld_lwu: size_mask = 3'd3;
        ld_ld:         size_mask = 3'd7;
        default:       size_mask = 3'd0;
      endcase
    end else if (ex.store_en) begin
      case (ex.store_len)
        sl_half:  size_mask = 3'd1;
        sl_word:  size_mask = 3'd3;
        sl_dword: size_mask = 3'd7;
        default:  size_mask = 3'd0;
      endcase
    end
  end

  a_natural_align: assert property (
    @(posedge clk) disable iff (!rstn)
    (ex.load_en || ex.store_en) |-> ((byte_off & size_mask) == 3'd0)
  ) else $error("mem_stage: misaligned access at %h", ex.alu_result);

endmodule

/* logic/exec_cluster.sv */
`timescale 1ns/1ps

module exec_cluster import rv_exec_pkg::*; (
  input  logic            clk,
  input  logic            rstn,
  input  dec_instr_t      instr,
  output wb_out_t         wb,
  output logic            redirect_en,
  output logic [xlen-1:0] redirect_pc
);

  ex_out_t         ex;
  logic            fw_en1;
  logic            fw_en2;
  logic [xlen-1:0] fw_data;
  logic            flush_nop;

  // ##################################################
  // redirect
  // ##################################################
  // jump or taken branch sitting in ex, so the input slot is wrong-path
  assign flush_nop = ex.jump_en | (ex.branch_en & ex.branch_result);

  assign redirect_en = flush_nop;
  assign redirect_pc = ex.branch_pc;

  fwd_unit fwd_unit_inst (
    .instr   (instr),
    .ex      (ex),
    .fw_en1  (fw_en1),
    .fw_en2  (fw_en2),
    .fw_data (fw_data)
  );

  exu exu_inst (
    .clk       (clk),
    .rstn      (rstn),
    .flush_nop (flush_nop),
    .instr     (instr),
    .fw_en1    (fw_en1),
    .fw_en2    (fw_en2),
    .fw_data   (fw_data),
    .ex        (ex)
  );

  mem_stage mem_stage_inst (
    .clk  (clk),
    .rstn (rstn),
    .ex   (ex),
    .wb   (wb)
  );

endmodule

/* bench/exec_cluster_tb.sv */
`timescale 1ns/1ps

module exec_cluster_tb import rv_exec_pkg::*; ();

  typedef struct packed {
    dec_instr_t      instr;
    logic            wb_valid;
    logic [4:0]      rd;
    logic [xlen-1:0] data;
    logic            redir;
    logic [xlen-1:0] target;
  } row_t;

  logic            clk;
  logic            rstn;
  dec_instr_t      instr;
  wb_out_t         wb;
  logic            redirect_en;
  logic [xlen-1:0] redirect_pc;

  row_t            rows[$];
  string           names[$];
  logic [7:0]      mem_model [256];
  logic            prev_fw;
  logic            prev_redir;
  logic [4:0]      prev_rd;
  logic [xlen-1:0] prev_res;

  exec_cluster exec_cluster_inst (
    .clk         (clk),
    .rstn        (rstn),
    .instr       (instr),
    .wb          (wb),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc)
  );

  always #10 clk = ~clk;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check(input string name, input logic [xlen-1:0] exp, input logic [xlen-1:0] act);
    if (exp !== act) begin
      fail_now($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
    end
  endtask

  // ##################################################
  // reference model
  // ##################################################
  function automatic logic [xlen-1:0] ref_alu(alu_op_e op, logic half, logic [xlen-1:0] a,
                                              logic [xlen-1:0] b, logic [xlen-1:0] pc);
    logic [31:0] a32;
    logic [31:0] b32;
    logic [31:0] r32;
    a32 = a[31:0];
    b32 = b[31:0];
    if (half) begin
      case (op)
        alu_add:  r32 = a32 + b32;
        alu_sub:  r32 = a32 - b32;
        alu_sll:  r32 = a32 << b32[4:0];
        alu_slt:  r32 = ($signed(a32) < $signed(b32)) ? 32'd1 : 32'd0;
        alu_sltu: r32 = (a32 < b32) ? 32'd1 : 32'd0;
        alu_xor:  r32 = a32 ^ b32;
        alu_srl:  r32 = a32 >> b32[4:0];
        alu_sra:  r32 = $signed(a32) >>> b32[4:0];
        alu_or:   r32 = a32 | b32;
        alu_and:  r32 = a32 & b32;
        alu_lui:  r32 = b32;
        default:  r32 = pc[31:0] + 32'd4;
      endcase
      return {{32{r32[31]}}, r32};
    end
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a - b;
      alu_sll:  return a << b[5:0];
      alu_slt:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      alu_sltu: return (a < b) ? 64'd1 : 64'd0;
      alu_xor:  return a ^ b;
      alu_srl:  return a >> b[5:0];
      alu_sra:  return $signed(a) >>> b[5:0];
      alu_or:   return a | b;
      alu_and:  return a & b;
      alu_lui:  return b;
      default:  return pc + 64'd4;
    endcase
  endfunction

  function automatic logic ref_branch(branch_op_e op, logic [xlen-1:0] a, logic [xlen-1:0] b);
    case (op)
      br_beq:  return a == b;
      br_bne:  return a != b;
      br_blt:  return $signed(a) < $signed(b);
      br_bge:  return $signed(a) >= $signed(b);
      br_bltu: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic int load_bytes(load_op_e op);
    case (op)
      ld_lb, ld_lbu: return 1;
      ld_lh, ld_lhu: return 2;
      ld_lw, ld_lwu: return 4;
      default:       return 8;
    endcase
  endfunction

  // expected write-back and redirect, tracking forwarding, flush and memory
  task automatic add_row(input string name, input dec_instr_t t);
    row_t            r;
    logic [xlen-1:0] v1;
    logic [xlen-1:0] v2;
    logic [xlen-1:0] res;
    logic [xlen-1:0] raw;
    logic            flushed;
    logic [7:0]      addr;
    int              nb;
    flushed = prev_redir;
    v1 = (prev_fw && t.index_rs1 == prev_rd) ? prev_res : t.gpr_data1;
    v2 = (prev_fw && t.index_rs2 == prev_rd) ? prev_res : t.gpr_data2;
    res = t.alu_en ? ref_alu(t.alu_opcode, t.alu_halfop, t.alu_pc_en ? t.pc : v1,
                             t.alu_imm_en ? t.imm : v2, t.pc) : '0;
    addr = res[7:0];
    // store data is the register value as issued
    if (t.store_en && !flushed) begin
      for (int b = 0; b < int'(t.store_len); b++) begin
        mem_model[8'(addr + b)] = t.gpr_data2[b*8 +: 8];
      end
    end
    nb = load_bytes(t.load_opcode);
    raw = '0;
    for (int b = 0; b < nb; b++) begin
      raw[b*8 +: 8] = mem_model[8'(addr + b)];
    end
    if ((t.load_opcode inside {ld_lb, ld_lh, ld_lw}) && raw[nb*8-1]) begin
      raw = raw | ({xlen{1'b1}} << (nb * 8));
    end
    r.instr    = t;
    r.wb_valid = !flushed && t.wb_en && (t.index_rd != '0);
    r.rd       = t.index_rd;
    r.data     = (t.wb_choose == wb_load) ? raw : res;
    r.redir    = !flushed && (t.jump_en || (t.branch_en && ref_branch(t.branch_opcode, v1, v2)));
    r.target   = t.pc + t.imm;
    prev_redir = r.redir;
    prev_fw    = !flushed && t.wb_en && (t.wb_choose == wb_alu) && (t.index_rd != '0);
    prev_rd    = t.index_rd;
    prev_res   = res;
    rows.push_back(r);
    names.push_back(name);
  endtask

  // ##################################################
  // instruction builders
  // ##################################################
  function automatic dec_instr_t bubble();
    dec_instr_t t;
    t = '0;
    t.wb_choose = wb_none;
    return t;
  endfunction

  function automatic dec_instr_t alu_instr(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2,
                                           alu_op_e op, logic [xlen-1:0] d1, logic [xlen-1:0] d2);
    dec_instr_t t;
    t = bubble();
    t.index_rd   = rd;
    t.index_rs1  = rs1;
    t.index_rs2  = rs2;
    t.alu_en     = 1'b1;
    t.alu_opcode = op;
    t.gpr_data1  = d1;
    t.gpr_data2  = d2;
    t.wb_en      = 1'b1;
    t.wb_choose  = wb_alu;
    return t;
  endfunction

  function automatic dec_instr_t mem_access(logic store, logic [3:0] len, load_op_e lop,
                                            logic [7:0] addr, logic [xlen-1:0] data,
                                            logic [4:0] rd);
    dec_instr_t t;
    t = alu_instr(store ? 5'd0 : rd, 5'd13, 5'd0, alu_add, {56'b0, addr & 8'hf8}, data);
    t.alu_imm_en  = 1'b1;
    t.imm         = {61'b0, addr[2:0]};
    t.store_en    = store;
    t.store_len   = len;
    t.load_en     = !store;
    t.load_opcode = lop;
    t.wb_en       = !store;
    t.wb_choose   = store ? wb_none : wb_load;
    return t;
  endfunction

  function automatic dec_instr_t branch_instr(branch_op_e op, logic [xlen-1:0] a,
                                              logic [xlen-1:0] b, logic [xlen-1:0] pc);
    dec_instr_t t;
    t = bubble();
    t.index_rs1     = 5'd11;
    t.index_rs2     = 5'd12;
    t.branch_en     = 1'b1;
    t.branch_opcode = op;
    t.gpr_data1     = a;
    t.gpr_data2     = b;
    t.pc            = pc;
    t.imm           = 64'hffff_ffff_ffff_ffe0;
    return t;
  endfunction

  // ##################################################
  // stimulus table and run
  // ##################################################
  initial begin
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] x;
    logic [7:0]      addr8;
    dec_instr_t      t;
    alu_op_e         op;
    branch_op_e      br;
    load_op_e        lop;
    int              slot;
    logic            seen;
    void'($urandom(32'hd3ed9ce6));
    clk        = 1'b0;
    rstn       = 1'b0;
    instr      = bubble();
    prev_fw    = 1'b0;
    prev_redir = 1'b0;
    prev_rd    = '0;
    prev_res   = '0;
    foreach (mem_model[i]) begin
      mem_model[i] = 8'h00;
    end

    for (int i = 0; i < 3; i++) begin
      add_row($sformatf("reset_bubble_%0d", i), bubble());
    end

    // register, imm and pc+imm operands, full and word width
    for (int o = 0; o < 12; o++) begin
      for (int h = 0; h < 2; h++) begin
        for (int v = 0; v < 3; v++) begin
          op = alu_op_e'(o);
          a = {$urandom, $urandom};
          b = {$urandom, $urandom};
          t = alu_instr(5'(o + 1), 5'd20, 5'd21, op, a, b);
          t.alu_halfop = h[0];
          t.alu_imm_en = (v != 0);
          t.alu_pc_en  = (v == 2);
          t.imm        = {$urandom, $urandom};
          t.pc         = {32'b0, $urandom & 32'hffff_fffc};
          add_row($sformatf("%s_h%0d_v%0d", op.name(), h, v), t);
        end
      end
    end

    a = {$urandom, $urandom};
    b = {$urandom, $urandom};
    add_row("fwd_src", alu_instr(5'd5, 5'd20, 5'd21, alu_add, a, b));
    add_row("fwd_rs1", alu_instr(5'd6, 5'd5, 5'd21, alu_sub, 64'hdead, b));
    add_row("fwd_rs2", alu_instr(5'd7, 5'd20, 5'd6, alu_xor, a, 64'hbeef));
    add_row("fwd_both", alu_instr(5'd8, 5'd7, 5'd7, alu_add, 64'h1, 64'h2));
    add_row("x0_write", alu_instr(5'd0, 5'd20, 5'd21, alu_or, a, b));
    add_row("x0_no_fwd", alu_instr(5'd9, 5'd0, 5'd0, alu_add, 64'h11, 64'h22));

    // equal, smaller and larger operand pairs, each followed by a victim
    slot = 0;
    for (int o = 0; o < 8; o++) begin
      if (o != 2 && o != 3) begin
        for (int p = 0; p < 3; p++) begin
          br = branch_op_e'(o);
          x = {$urandom, $urandom};
          a = (p == 2) ? x + 64'd1 : x;
          b = (p == 1) ? x + 64'd1 : x;
          add_row($sformatf("%s_p%0d", br.name(), p),
                  branch_instr(br, a, b, 64'h1000 + 64'(o * 64)));
          if (p == 1) begin
            add_row("after_branch_store", mem_access(1'b1, sl_dword, ld_ld, 8'(8'h80 + slot * 8),
                                                     {$urandom, $urandom}, 5'd0));
            slot++;
          end else begin
            add_row("after_branch_alu", alu_instr(5'd10, 5'd20, 5'd21, alu_add, a, b));
          end
        end
      end
    end
    for (int s = 0; s < slot; s++) begin
      add_row($sformatf("reload_%0d", s),
              mem_access(1'b0, 4'd0, ld_ld, 8'(8'h80 + s * 8), '0, 5'd14));
    end

    t = alu_instr(5'd1, 5'd0, 5'd0, alu_link, '0, '0);
    t.jump_en = 1'b1;
    t.pc      = 64'h2000;
    t.imm     = 64'h124;
    add_row("jal", t);
    add_row("after_jal", alu_instr(5'd2, 5'd20, 5'd21, alu_add, 64'h5, 64'h6));
    t.index_rd = 5'd3;
    t.pc       = 64'h3000;
    t.imm      = 64'hffff_ffff_ffff_ff00;
    add_row("jump_back", t);
    add_row("after_jump_store", mem_access(1'b1, sl_dword, ld_ld, 8'hb0, 64'h1234, 5'd0));
    add_row("reload_b0", mem_access(1'b0, 4'd0, ld_ld, 8'hb0, '0, 5'd14));

    add_row("sd_10", mem_access(1'b1, sl_dword, ld_ld, 8'h10, {$urandom, $urandom}, 5'd0));
    add_row("sw_14", mem_access(1'b1, sl_word, ld_ld, 8'h14, {$urandom, $urandom}, 5'd0));
    add_row("sh_12", mem_access(1'b1, sl_half, ld_ld, 8'h12, {$urandom, $urandom}, 5'd0));
    add_row("sb_17", mem_access(1'b1, sl_byte, ld_ld, 8'h17, {$urandom, $urandom}, 5'd0));
    add_row("sb_11", mem_access(1'b1, sl_byte, ld_ld, 8'h11, {$urandom, $urandom}, 5'd0));
    add_row("sd_20", mem_access(1'b1, sl_dword, ld_ld, 8'h20, {$urandom, $urandom}, 5'd0));
    add_row("sw_28", mem_access(1'b1, sl_word, ld_ld, 8'h28, {$urandom, $urandom}, 5'd0));
    add_row("sh_2e", mem_access(1'b1, sl_half, ld_ld, 8'h2e, {$urandom, $urandom}, 5'd0));
    add_row("sb_2d", mem_access(1'b1, sl_byte, ld_ld, 8'h2d, {$urandom, $urandom}, 5'd0));
    for (int l = 0; l < 7; l++) begin
      for (int n = 0; n < 3; n++) begin
        lop = load_op_e'(l);
        addr8 = 8'h10 + (8'($urandom) & 8'h1f & ~8'(load_bytes(lop) - 1));
        add_row($sformatf("%s_%h", lop.name(), addr8),
                mem_access(1'b0, 4'd0, lop, addr8, '0, 5'(14 + n)));
      end
    end

    repeat (5) @(negedge clk);
    rstn = 1'b1;

    // redirect of a row one cycle after issue, write-back two cycles after
    for (int k = 0; k < rows.size() + 2; k++) begin
      @(negedge clk);
      if (k >= 1) begin
        check({names[k-1], " redirect_en"}, 64'(rows[k-1].redir), 64'(redirect_en));
        if (rows[k-1].redir) begin
          check({names[k-1], " redirect_pc"}, rows[k-1].target, redirect_pc);
        end
      end
      if (k >= 2) begin
        check({names[k-2], " wb_valid"}, 64'(rows[k-2].wb_valid), 64'(wb.wb_valid));
        if (rows[k-2].wb_valid) begin
          check({names[k-2], " index_rd"}, 64'(rows[k-2].rd), 64'(wb.index_rd));
          check({names[k-2], " wb_data"}, rows[k-2].data, wb.wb_data);
        end
      end
      instr = (k < rows.size()) ? rows[k].instr : bubble();
    end

    instr = alu_instr(5'd4, 5'd20, 5'd21, alu_add, 64'd40, 64'd2);
    seen = 1'b0;
    for (int c = 0; c < 8 && !seen; c++) begin
      @(negedge clk);
      instr = bubble();
      seen = wb.wb_valid;
    end
    if (!seen) begin
      fail_now("write-back of the last instruction did not arrive within 8 cycles");
    end else begin
      check("final_wb", 64'd42, wb.wb_data);
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

/* exec_cluster.f */
logic/rv_exec_pkg.sv
logic/alu.sv
logic/fwd_unit.sv
logic/exu.sv
logic/mem_stage.sv
logic/exec_cluster.sv
bench/exec_cluster_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the execute cluster testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module exec_cluster_tb -f exec_cluster.f \
  && ./obj_dir/Vexec_cluster_tb | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
